// File: dv/branch_checker.sv
module branch_checker (
  input  logic               clk,
  input  branch_pkg::flush_t flush,
  input  branch_pkg::addr_t  jump_address,
  input  branch_pkg::addr_t  read_val,
  input  logic               read_valid,
  input  csr_pkg::pdata_t    prdata,
  input  logic               pready,
  input  logic               pslverr
);

  import branch_pkg::*;
  import csr_pkg::*;

  localparam int apb_timeout = 16;

  int errors;
  int passes;

  initial begin
    errors = 0;
    passes = 0;
  end

  task automatic score(input string name, input bit ok, input string detail);
    if (ok) begin
      passes++;
      $display("ok    %s", name);
    end else begin
      errors++;
      $display("error %s %s", name, detail);
    end
  endtask

  // combinational outputs settle after the falling edge.
  task automatic check_branch(input string name, input flush_t exp_flush,
                              input addr_t exp_addr);
    @(posedge clk);
    score(name, flush === exp_flush && jump_address === exp_addr,
          $sformatf("expected %h/%h actual %h/%h", exp_flush, exp_addr, flush, jump_address));
  endtask

  task automatic check_lookup(input string name, input logic exp_valid, input addr_t exp_val);
    @(posedge clk);
    @(negedge clk);   // registered result is stable here.
    score(name, read_valid === exp_valid && (!exp_valid || read_val === exp_val),
          $sformatf("expected %b/%h actual %b/%h", exp_valid, exp_val, read_valid, read_val));
  endtask

  // ******************************
  // apb access phase
  // ******************************
  task automatic check_apb(input string name, input logic check_data, input pdata_t exp_data,
                           input logic exp_err);
    int waited;
    waited = 0;
    @(posedge clk);
    while (pready !== 1'b1 && waited < apb_timeout) begin
      @(posedge clk);
      waited++;
    end
    if (pready !== 1'b1) begin
      errors++;
      $display("%s timed out, pready never came high", name);
    end else if (check_data) begin
      score(name, prdata === exp_data && pslverr === exp_err,
            $sformatf("expected %h/%b actual %h/%b", exp_data, exp_err, prdata, pslverr));
    end else begin
      score(name, pslverr === exp_err,
            $sformatf("expected pslverr %b actual %b", exp_err, pslverr));
    end
  endtask

  task automatic print_counts();
    $display("%0d tests, %0d passed, %0d failed", passes + errors, passes, errors);
  endtask

endmodule

// File: dv/branch_tb.sv
module branch_tb;

  import branch_pkg::*;
  import csr_pkg::*;

  localparam int lut_depth = 16;

  logic   clk;
  logic   reset;
  logic   zero, less, greater;
  jop_t   jop;
  addr_t  pc, reg_address, imm_address;
  addr_t  read_key;
  flush_t flush;
  addr_t  jump_address;
  addr_t  read_val;
  logic   read_valid;
  logic   psel, penable, pwrite;
  paddr_t paddr;
  pdata_t pwdata;
  pdata_t prdata;
  logic   pready;
  logic   pslverr;

  // ******************************
  // stimulus table
  // ******************************
  string      row_name[$];
  jop_t       row_jop[$];
  logic [2:0] row_flags[$];   // zero, less, greater.
  addr_t      row_reg[$];
  addr_t      row_imm[$];
  flush_t     row_flush[$];
  addr_t      row_target[$];

  int    exp_redirects;
  int    exp_jumps;
  addr_t branch_pc;

  branch_top #(.lut_depth(lut_depth)) u_branch_top (.*);

  branch_checker u_checker (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic void add_row(input string name, input jop_t op, input logic [2:0] flags,
                                  input addr_t reg_a, input addr_t imm_a,
                                  input flush_t exp_flush, input addr_t exp_target);
    row_name.push_back(name);
    row_jop.push_back(op);
    row_flags.push_back(flags);
    row_reg.push_back(reg_a);
    row_imm.push_back(imm_a);
    row_flush.push_back(exp_flush);
    row_target.push_back(exp_target);
  endfunction

  // one execute cycle and then a bubble.
  task automatic resolve(input string name, input jop_t op, input logic [2:0] flags,
                         input addr_t pc_a, input addr_t reg_a, input addr_t imm_a,
                         input flush_t exp_flush, input addr_t exp_target);
    jop = op;
    {zero, less, greater} = flags;
    pc = pc_a;
    reg_address = reg_a;
    imm_address = imm_a;
    u_checker.check_branch(name, exp_flush, exp_target);
    @(negedge clk);
    jop = JOP_NOP;
    {zero, less, greater} = 3'b000;
  endtask

  task automatic lookup(input string name, input addr_t key, input logic exp_valid,
                        input addr_t exp_val);
    read_key = key;
    u_checker.check_lookup(name, exp_valid, exp_val);
  endtask

  task automatic apb(input string name, input logic write, input paddr_t addr,
                     input pdata_t data, input logic exp_err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = write ? data : '0;
    @(negedge clk);
    penable = 1'b1;   // access phase.
    u_checker.check_apb(name, !write && !exp_err, data, exp_err);
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h6ddb));
    reset = 1'b1;
    {zero, less, greater} = 3'b000;
    jop = JOP_NOP;
    {pc, reg_address, imm_address, read_key} = '0;
    {psel, penable, pwrite} = 3'b000;
    paddr = '0;
    pwdata = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    resolve("reset_flush", JOP_NOP, 3'b000, '0, '0, '0, FLUSH_NONE, '0);
    lookup("reset_lookup", $urandom, 1'b0, '0);
    apb("reset_redirects", 1'b0, REG_REDIRECTS, '0, 1'b0);
    apb("reset_jumps", 1'b0, REG_JUMPS, '0, 1'b0);
    apb("unknown_offset", 1'b0, 8'h0c, '0, 1'b1);

    // ******************************
    // opcode decode
    // ******************************
    add_row("nop_flags_set",   JOP_NOP, 3'b111, 32'h8010, 32'h4010, FLUSH_NONE,   32'h4010);
    add_row("nop_flags_clear", JOP_NOP, 3'b000, 32'h8020, 32'h4020, FLUSH_NONE,   32'h4020);
    add_row("j_flags_set",     JOP_J,   3'b111, 32'h8030, 32'h4030, FLUSH_EX_MEM, 32'h4030);
    add_row("j_flags_clear",   JOP_J,   3'b000, 32'h8040, 32'h4040, FLUSH_EX_MEM, 32'h4040);
    add_row("jr_flags_set",    JOP_JR,  3'b111, 32'h8050, 32'h4050, FLUSH_ALL,    32'h8050);
    add_row("jr_flags_clear",  JOP_JR,  3'b000, 32'h8060, 32'h4060, FLUSH_ALL,    32'h8060);
    add_row("jeq_taken",       JOP_JEQ, 3'b100, 32'h8070, 32'h4070, FLUSH_ALL,    32'h4070);
    add_row("jeq_not_taken",   JOP_JEQ, 3'b010, 32'h8080, 32'h4080, FLUSH_NONE,   32'h4080);
    add_row("jne_taken",       JOP_JNE, 3'b010, 32'h8090, 32'h4090, FLUSH_ALL,    32'h4090);
    add_row("jne_not_taken",   JOP_JNE, 3'b100, 32'h80a0, 32'h40a0, FLUSH_NONE,   32'h40a0);
    add_row("jl_taken",        JOP_JL,  3'b010, 32'h80b0, 32'h40b0, FLUSH_ALL,    32'h40b0);
    add_row("jl_not_taken",    JOP_JL,  3'b001, 32'h80c0, 32'h40c0, FLUSH_NONE,   32'h40c0);
    add_row("jle_equal",       JOP_JLE, 3'b100, 32'h80d0, 32'h40d0, FLUSH_ALL,    32'h40d0);
    add_row("jle_not_taken",   JOP_JLE, 3'b001, 32'h80e0, 32'h40e0, FLUSH_NONE,   32'h40e0);
    add_row("jg_taken",        JOP_JG,  3'b001, 32'h80f0, 32'h40f0, FLUSH_ALL,    32'h40f0);
    add_row("jg_not_taken",    JOP_JG,  3'b100, 32'h8100, 32'h4100, FLUSH_NONE,   32'h4100);
    add_row("jge_equal",       JOP_JGE, 3'b100, 32'h8110, 32'h4110, FLUSH_ALL,    32'h4110);
    add_row("jge_not_taken",   JOP_JGE, 3'b010, 32'h8120, 32'h4120, FLUSH_NONE,   32'h4120);
    add_row("jz_taken",        JOP_JZ,  3'b100, 32'h8130, 32'h4130, FLUSH_ALL,    32'h4130);
    add_row("jz_not_taken",    JOP_JZ,  3'b011, 32'h8140, 32'h4140, FLUSH_NONE,   32'h4140);
    add_row("jnz_taken",       JOP_JNZ, 3'b001, 32'h8150, 32'h4150, FLUSH_ALL,    32'h4150);
    add_row("jnz_not_taken",   JOP_JNZ, 3'b100, 32'h8160, 32'h4160, FLUSH_NONE,   32'h4160);

    exp_redirects = 0;
    exp_jumps = 0;
    foreach (row_name[i]) begin
      branch_pc = $urandom & 32'hffff_fffc;
      resolve(row_name[i], row_jop[i], row_flags[i], branch_pc, row_reg[i], row_imm[i],
              row_flush[i], row_target[i]);
      if ((row_flush[i] & FLUSH_PC) != FLUSH_NONE) begin
        exp_redirects++;
      end
      if (row_jop[i] != JOP_NOP) begin
        exp_jumps++;
      end
    end
    apb("redirect_count", 1'b0, REG_REDIRECTS, exp_redirects, 1'b0);
    apb("jump_count", 1'b0, REG_JUMPS, exp_jumps, 1'b0);

    // ******************************
    // table learning
    // ******************************
    apb("ctrl_clear", 1'b1, REG_CTRL, 32'h3, 1'b0);   // learn on and drop the random pcs.
    apb("ctrl_readback", 1'b0, REG_CTRL, 32'h1, 1'b0);
    resolve("jeq_learn", JOP_JEQ, 3'b100, 32'h1010, 32'h9000, 32'h2468,
            FLUSH_ALL, 32'h2468);
    lookup("hit_after_redirect", 32'h1010, 1'b1, 32'h2468);
    lookup("miss_other_tag", 32'h1010 + lut_depth * 4, 1'b0, '0);   // same index.
    resolve("jne_no_learn", JOP_JNE, 3'b100, 32'h1020, 32'h9000, 32'h3000,
            FLUSH_NONE, 32'h3000);
    resolve("j_no_learn", JOP_J, 3'b111, 32'h1030, 32'h9000, 32'h3100,
            FLUSH_EX_MEM, 32'h3100);
    lookup("miss_not_taken", 32'h1020, 1'b0, '0);
    lookup("miss_plain_jump", 32'h1030, 1'b0, '0);
    apb("learn_off", 1'b1, REG_CTRL, 32'h0, 1'b0);
    resolve("jr_unlearned", JOP_JR, 3'b000, 32'h1040, 32'h9100, 32'h3200,
            FLUSH_ALL, 32'h9100);
    lookup("miss_learn_off", 32'h1040, 1'b0, '0);
    lookup("hit_before_clear", 32'h1010, 1'b1, 32'h2468);
    apb("clear_table", 1'b1, REG_CTRL, 32'h3, 1'b0);
    lookup("miss_after_clear", 32'h1010, 1'b0, '0);

    u_checker.print_counts();
    if (u_checker.errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/branch_csr.sv
module branch_csr (
  input  logic            clk,
  input  logic            reset,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  csr_pkg::paddr_t paddr,
  input  csr_pkg::pdata_t pwdata,
  output csr_pkg::pdata_t prdata,
  output logic            pready,
  output logic            pslverr,
  input  logic            redirect,
  input  logic            jump,
  output logic            learn,
  output logic            clear
);

  import csr_pkg::*;

  logic   access;
  logic   ctrl_write;
  logic   known;
  pdata_t rdata;
  pdata_t redirects;
  pdata_t jumps;

  assign access     = psel && penable;
  assign ctrl_write = access && pwrite && (paddr == REG_CTRL);

  // ******************************
  // control register
  // ******************************
  always_ff @(posedge clk) begin
    if (reset) begin
      learn <= 1'b1;
    end else if (ctrl_write) begin
      learn <= pwdata[CTRL_LEARN];
    end
  end

  assign clear = ctrl_write && pwdata[CTRL_CLEAR];   // one access phase wide.

  // ******************************
  // event counters
  // ******************************
  always_ff @(posedge clk) begin
    if (reset) begin
      redirects <= '0;
      jumps     <= '0;
    end else begin
      if (redirect) begin
        redirects <= redirects + 1'b1;
      end
      if (jump) begin
        jumps <= jumps + 1'b1;
      end
    end
  end

  // ******************************
  // read mux
  // ******************************
  always_comb begin
    known = 1'b1;
    rdata = '0;
    case (paddr)
      REG_CTRL:      rdata[CTRL_LEARN] = learn;   // clear reads as 0.
      REG_REDIRECTS: rdata = redirects;
      REG_JUMPS:     rdata = jumps;
      default:       known = 1'b0;
    endcase
  end

  assign prdata  = (access && !pwrite) ? rdata : '0;
  assign pready  = 1'b1;   // no wait states.
  assign pslverr = access && !known;

endmodule

// File: hdl/branch_pkg.sv
package branch_pkg;

  // ******************************
  // instruction addresses
  // ******************************
  localparam int ADDR_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // ******************************
  // jump opcodes
  // ******************************
  typedef enum logic [3:0] {
    JOP_NOP = 4'd0,
    JOP_J   = 4'd1,   // unconditional and resolved late.
    JOP_JR  = 4'd2,   // target from register.
    JOP_JEQ = 4'd3,
    JOP_JNE = 4'd4,
    JOP_JL  = 4'd5,
    JOP_JLE = 4'd6,
    JOP_JG  = 4'd7,
    JOP_JGE = 4'd8,
    JOP_JZ  = 4'd9,
    JOP_JNZ = 4'd10
  } jop_t;

  // ******************************
  // pipeline flush mask
  // ******************************
  localparam int FLUSH_BITS = 4;

  // one bit per pipeline register.
  typedef logic [FLUSH_BITS-1:0] flush_t;

  localparam flush_t FLUSH_NONE   = 4'b0000;
  localparam flush_t FLUSH_PC     = 4'b0001;
  localparam flush_t FLUSH_IF_ID  = 4'b0010;
  localparam flush_t FLUSH_ID_EX  = 4'b0100;
  localparam flush_t FLUSH_EX_MEM = 4'b1000;

  localparam flush_t FLUSH_ALL = FLUSH_PC | FLUSH_IF_ID | FLUSH_ID_EX | FLUSH_EX_MEM;

endpackage

// File: hdl/branch_top.sv
module branch_top #(
  parameter int lut_depth = 16
) (
  input  logic               clk,
  input  logic               reset,
  // execute stage.
  input  logic               zero,
  input  logic               less,
  input  logic               greater,
  input  branch_pkg::jop_t   jop,
  input  branch_pkg::addr_t  pc,
  input  branch_pkg::addr_t  reg_address,
  input  branch_pkg::addr_t  imm_address,
  output branch_pkg::flush_t flush,
  output branch_pkg::addr_t  jump_address,
  // fetch lookup.
  input  branch_pkg::addr_t  read_key,
  output branch_pkg::addr_t  read_val,
  output logic               read_valid,
  // apb.
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  csr_pkg::paddr_t    paddr,
  input  csr_pkg::pdata_t    pwdata,
  output csr_pkg::pdata_t    prdata,
  output logic               pready,
  output logic               pslverr
);

  logic lut_write;
  logic redirect;
  logic jump;
  logic learn;
  logic clear;

  branch_unit u_branch_unit (
    .clk          (clk),
    .reset        (reset),
    .zero         (zero),
    .less         (less),
    .greater      (greater),
    .jop          (jop),
    .pc           (pc),
    .reg_address  (reg_address),
    .imm_address  (imm_address),
    .learn        (learn),
    .flush        (flush),
    .jump_address (jump_address),
    .lut_write    (lut_write),
    .redirect     (redirect),
    .jump         (jump)
  );

  // resolved targets keyed by the branch pc.
  lut #(
    .lut_depth (lut_depth)
  ) u_lut (
    .clk        (clk),
    .reset      (reset),
    .clear      (clear),
    .write      (lut_write),
    .write_key  (pc),
    .write_val  (jump_address),
    .read_key   (read_key),
    .read_val   (read_val),
    .read_valid (read_valid)
  );

  branch_csr u_branch_csr (
    .clk      (clk),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .redirect (redirect),
    .jump     (jump),
    .learn    (learn),
    .clear    (clear)
  );

endmodule

// File: hdl/branch_unit.sv
module branch_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               zero,
  input  logic               less,
  input  logic               greater,
  input  branch_pkg::jop_t   jop,
  input  branch_pkg::addr_t  pc,
  input  branch_pkg::addr_t  reg_address,
  input  branch_pkg::addr_t  imm_address,
  input  logic               learn,
  output branch_pkg::flush_t flush,
  output branch_pkg::addr_t  jump_address,
  output logic               lut_write,
  output logic               redirect,
  output logic               jump
);

  import branch_pkg::*;

  logic taken;   // condition of a conditional jump.

  // ******************************
  // condition decode
  // ******************************
  always_comb begin
    case (jop)
      JOP_JEQ,
      JOP_JZ:  taken = zero;
      JOP_JNE,
      JOP_JNZ: taken = !zero;
      JOP_JL:  taken = less;
      JOP_JLE: taken = less || zero;
      JOP_JG:  taken = greater;
      JOP_JGE: taken = greater || zero;
      default: taken = 1'b0;
    endcase
  end

  // ******************************
  // flush mask
  // ******************************
  always_comb begin
    case (jop)
      JOP_NOP: flush = FLUSH_NONE;
      JOP_J:   flush = FLUSH_EX_MEM;   // fetch already redirected.
      JOP_JR:  flush = FLUSH_ALL;
      default: flush = taken ? FLUSH_ALL : FLUSH_NONE;
    endcase
  end

  assign jump_address = (jop == JOP_JR) ? reg_address : imm_address;

  // pc redirect drives the counters and table learning.
  assign redirect  = (flush & FLUSH_PC) != FLUSH_NONE;
  assign lut_write = redirect && learn;
  assign jump      = jop != JOP_NOP;

  // ******************************
  // assertions
  // ******************************
  a_nop_no_flush : assert property (
    @(posedge clk) disable iff (reset)
    (jop == JOP_NOP) |-> (flush == FLUSH_NONE)
  );

  a_write_needs_redirect : assert property (
    @(posedge clk) disable iff (reset)
    lut_write |-> ((flush & FLUSH_PC) != FLUSH_NONE)
  );

endmodule

// File: hdl/csr_pkg.sv
package csr_pkg;

  // ******************************
  // apb bus
  // ******************************
  localparam int PADDR_WIDTH = 8;
  localparam int PDATA_WIDTH = 32;

  typedef logic [PADDR_WIDTH-1:0] paddr_t;
  typedef logic [PDATA_WIDTH-1:0] pdata_t;

  // ******************************
  // register map
  // ******************************
  localparam paddr_t REG_CTRL      = 8'h00;
  localparam paddr_t REG_REDIRECTS = 8'h04;   // taken redirects.
  localparam paddr_t REG_JUMPS     = 8'h08;   // all jump opcodes.

  // REG_CTRL bits.
  localparam int CTRL_LEARN = 0;
  localparam int CTRL_CLEAR = 1;   // self clearing.

endpackage

// File: hdl/lut.sv
module lut #(
  parameter int lut_depth = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  logic              write,
  input  branch_pkg::addr_t write_key,
  input  branch_pkg::addr_t write_val,
  input  branch_pkg::addr_t read_key,
  output branch_pkg::addr_t read_val,
  output logic              read_valid
);

  import branch_pkg::*;

  localparam int idx_width = $clog2(lut_depth);
  localparam int tag_width = ADDR_WIDTH - idx_width - 2;

  typedef logic [idx_width-1:0] idx_t;
  typedef logic [tag_width-1:0] tag_t;

  logic [lut_depth-1:0] valid;
  tag_t                 tag_mem [lut_depth];
  addr_t                val_mem [lut_depth];

  idx_t wr_idx;
  idx_t rd_idx;
  tag_t wr_tag;
  tag_t rd_tag;

  // index sits above bit 1 of a word aligned key.
  assign wr_idx = write_key[idx_width+1:2];
  assign wr_tag = write_key[ADDR_WIDTH-1:idx_width+2];
  assign rd_idx = read_key[idx_width+1:2];
  assign rd_tag = read_key[ADDR_WIDTH-1:idx_width+2];

  // ******************************
  // write port
  // ******************************
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      valid <= '0;   // clear wins over a same cycle write.
    end else if (write) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      tag_mem[wr_idx] <= wr_tag;
      val_mem[wr_idx] <= write_val;
    end
  end

  // ******************************
  // read port
  // ******************************
  // same index write in this cycle is not seen.
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      read_valid <= 1'b0;
    end else begin
      read_valid <= valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    end
  end

  always_ff @(posedge clk) begin
    read_val <= val_mem[rd_idx];
  end

  a_no_hit_after_clear : assert property (
    @(posedge clk)
    (reset || clear) |=> !read_valid
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module branch_tb \
    -f tb.f -o branch_sim &&
  ./obj_dir/branch_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: tb.f
hdl/branch_pkg.sv
hdl/csr_pkg.sv
hdl/branch_unit.sv
hdl/lut.sv
hdl/branch_csr.sv
hdl/branch_top.sv
dv/branch_checker.sv
dv/branch_tb.sv
